// ==== source/adapter_pkg.sv ====
// adapter package
// shared widths, request kinds and AXI channel structs for the cache adapter
package adapter_pkg;

  // --------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------
  localparam int unsigned ADDR_WIDTH  = 32;
  localparam int unsigned DATA_WIDTH  = 64;
  localparam int unsigned STRB_WIDTH  = DATA_WIDTH / 8;
  localparam int unsigned ID_WIDTH    = 4;

  // byte offset bits inside one data beat
  localparam int unsigned BEAT_OFFSET = $clog2(STRB_WIDTH);

  // --------------------------------------------------------------------
  // basic types
  // --------------------------------------------------------------------
  typedef logic [DATA_WIDTH-1:0] beat_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

  // single beat access or a full cache line burst
  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_kind_t;

  // --------------------------------------------------------------------
  // AXI channel payloads
  // --------------------------------------------------------------------

  // shared by AR and AW, burst type is always incrementing
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    id_t                   id;
    logic [7:0]            len;
    logic [2:0]            size;
  } addr_chan_t;

  // write data beat
  typedef struct packed {
    beat_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // read data beat coming back from the slave
  typedef struct packed {
    beat_t      data;
    id_t        id;
    logic       last;
    logic [1:0] resp;
  } r_chan_t;

  // write response
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

endpackage

// ==== source/axi_read_engine.sv ====
// axi read engine
// single beat and cache line burst reads, line assembly and critical word flag
`timescale 1ns/100ps

module axi_read_engine
  import adapter_pkg::*;
#(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  req_kind_t              kind_i,
  input  logic [ADDR_WIDTH-1:0]  addr_i,
  input  logic [1:0]             size_i,
  input  id_t                    id_i,
  input  logic                   ar_ready_i,
  input  logic                   r_valid_i,
  input  r_chan_t                r_i,
  output logic                   ar_valid_o,
  output addr_chan_t             ar_o,
  output logic                   r_ready_o,
  output logic                   gnt_o,
  output logic                   done_o,
  output beat_t [LINE_BEATS-1:0] line_o,
  output id_t                    id_o,
  output logic                   crit_valid_o,
  output beat_t                  crit_word_o,
  output logic                   idle_o
);

  localparam int unsigned IDX_W       = $clog2(LINE_BEATS);
  localparam int unsigned LINE_OFFSET = BEAT_OFFSET + IDX_W;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA,
    RD_DONE
  } rd_state_t;

  rd_state_t              state_q, state_d;
  logic [IDX_W-1:0]       cnt_q;
  addr_chan_t             ar_q;
  req_kind_t              kind_q;
  logic [IDX_W-1:0]       offset_q;
  id_t                    id_q;
  beat_t [LINE_BEATS-1:0] line_q;
  logic [ADDR_WIDTH-1:0]  base_addr;
  logic [IDX_W-1:0]       beat_idx;
  logic                   r_hs;

  // line bursts start at the line base, single reads keep the address
  always_comb begin
    base_addr = addr_i;
    if (kind_i == LINE_REQ) begin
      base_addr[LINE_OFFSET-1:0] = '0;
    end
  end

  assign ar_valid_o   = (state_q == RD_ADDR);
  assign ar_o         = ar_q;
  assign r_ready_o    = (state_q == RD_DATA);
  assign gnt_o        = ar_valid_o && ar_ready_i;
  assign r_hs         = r_ready_o && r_valid_i;
  assign done_o       = (state_q == RD_DONE);
  assign idle_o       = (state_q == RD_IDLE);
  assign line_o       = line_q;
  assign id_o         = id_q;
  assign beat_idx     = (kind_q == LINE_REQ) ? cnt_q : '0;
  // the beat covering the requested address is the critical word
  assign crit_valid_o = r_hs && ((kind_q == SINGLE_REQ) || (cnt_q == offset_q));
  assign crit_word_o  = r_i.data;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (start_i) state_d = RD_ADDR;
      RD_ADDR: if (ar_ready_i) state_d = RD_DATA;
      RD_DATA: if (r_hs && r_i.last) state_d = RD_DONE;
      RD_DONE: state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  // --------------------------------------------------------------------
  // control registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= RD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start_i && idle_o) begin
        cnt_q <= '0;
      end else if (r_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // request and line payload
  always_ff @(posedge clk_i) begin
    if (start_i && idle_o) begin
      ar_q.addr <= base_addr;
      ar_q.id   <= id_i;
      ar_q.len  <= (kind_i == LINE_REQ) ? 8'(LINE_BEATS - 1) : 8'd0;
      ar_q.size <= (kind_i == LINE_REQ) ? 3'(BEAT_OFFSET) : {1'b0, size_i};
      kind_q    <= kind_i;
      offset_q  <= addr_i[BEAT_OFFSET +: IDX_W];
    end
    if (r_hs) begin
      line_q[beat_idx] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

  // --------------------------------------------------------------------
  // protocol checks
  // --------------------------------------------------------------------
  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("read address changed before ar_ready");

  // slave burst length must agree with the requested len
  a_r_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_hs |-> (r_i.last == (cnt_q == ar_q.len[IDX_W-1:0])))
    else $error("r last does not match the requested burst length");

endmodule

// ==== source/axi_write_engine.sv ====
// axi write engine
// single beat and cache line burst writes, then waits for the write response
`timescale 1ns/100ps

module axi_write_engine
  import adapter_pkg::*;
#(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  req_kind_t              kind_i,
  input  logic [ADDR_WIDTH-1:0]  addr_i,
  input  logic [1:0]             size_i,
  input  id_t                    id_i,
  input  beat_t [LINE_BEATS-1:0] wdata_i,
  input  strb_t [LINE_BEATS-1:0] be_i,
  input  logic                   aw_ready_i,
  input  logic                   w_ready_i,
  input  logic                   b_valid_i,
  input  b_chan_t                b_i,
  output logic                   aw_valid_o,
  output addr_chan_t             aw_o,
  output logic                   w_valid_o,
  output w_chan_t                w_o,
  output logic                   b_ready_o,
  output logic                   gnt_o,
  output logic                   done_o,
  output id_t                    id_o,
  output logic                   idle_o
);

  localparam int unsigned      IDX_W       = $clog2(LINE_BEATS);
  localparam int unsigned      LINE_OFFSET = BEAT_OFFSET + IDX_W;
  localparam logic [IDX_W-1:0] LAST_IDX    = IDX_W'(LINE_BEATS - 1);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_RESP
  } wr_state_t;

  wr_state_t             state_q, state_d;
  logic                  aw_done_q, aw_done_d;
  logic                  w_done_q, w_done_d;
  logic [IDX_W-1:0]      cnt_q, cnt_d;
  addr_chan_t            aw_q;
  req_kind_t             kind_q;
  logic [ADDR_WIDTH-1:0] base_addr;
  logic [IDX_W-1:0]      beat_idx;
  logic                  w_last;
  logic                  aw_hs;
  logic                  w_hs;

  always_comb begin
    base_addr = addr_i;
    if (kind_i == LINE_REQ) begin
      base_addr[LINE_OFFSET-1:0] = '0;
    end
  end

  // address and data channels run independently while sending
  assign aw_valid_o = (state_q == WR_SEND) && !aw_done_q;
  assign w_valid_o  = (state_q == WR_SEND) && !w_done_q;
  assign aw_o       = aw_q;
  assign aw_hs      = aw_valid_o && aw_ready_i;
  assign w_hs       = w_valid_o && w_ready_i;

  // cache holds the line data until gnt, so beats are picked straight from it
  assign beat_idx   = (kind_q == LINE_REQ) ? cnt_q : '0;
  assign w_last     = (kind_q == SINGLE_REQ) || (cnt_q == LAST_IDX);
  assign w_o.data   = wdata_i[beat_idx];
  assign w_o.strb   = be_i[beat_idx];
  assign w_o.last   = w_last;

  assign b_ready_o  = (state_q == WR_RESP);
  assign done_o     = b_ready_o && b_valid_i;
  assign id_o       = b_i.id;
  assign idle_o     = (state_q == WR_IDLE);

  always_comb begin
    state_d   = state_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    cnt_d     = cnt_q;
    gnt_o     = 1'b0;
    case (state_q)
      WR_IDLE: begin
        if (start_i) begin
          state_d   = WR_SEND;
          aw_done_d = 1'b0;
          w_done_d  = 1'b0;
          cnt_d     = '0;
        end
      end
      WR_SEND: begin
        if (aw_hs) begin
          aw_done_d = 1'b1;
        end
        if (w_hs) begin
          if (w_last) begin
            w_done_d = 1'b1;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
        // grant once both address and last beat are through
        if (aw_done_d && w_done_d) begin
          gnt_o   = 1'b1;
          state_d = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_valid_i) state_d = WR_IDLE;
      end
      default: state_d = WR_IDLE;
    endcase
  end

  // --------------------------------------------------------------------
  // registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= WR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      cnt_q     <= '0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
      cnt_q     <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && idle_o) begin
      aw_q.addr <= base_addr;
      aw_q.id   <= id_i;
      aw_q.len  <= (kind_i == LINE_REQ) ? 8'(LINE_BEATS - 1) : 8'd0;
      aw_q.size <= (kind_i == LINE_REQ) ? 3'(BEAT_OFFSET) : {1'b0, size_i};
      kind_q    <= kind_i;
    end
  end

  // beats sent must agree with the len on the address channel
  a_w_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_valid_o && w_o.last |-> (cnt_q == aw_q.len[IDX_W-1:0]))
    else $error("w last does not match the burst length on aw");

endmodule

// ==== source/adapter_ctrl.sv ====
// request controller
// steers cache requests to the read or write engine and merges their results
`timescale 1ns/100ps

module adapter_ctrl
  import adapter_pkg::*;
#(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic                   rd_gnt_i,
  input  logic                   rd_done_i,
  input  beat_t [LINE_BEATS-1:0] rd_data_i,
  input  id_t                    rd_id_i,
  input  logic                   rd_idle_i,
  input  logic                   wr_gnt_i,
  input  logic                   wr_done_i,
  input  id_t                    wr_id_i,
  input  logic                   wr_idle_i,
  output logic                   rd_start_o,
  output logic                   wr_start_o,
  output logic                   gnt_o,
  output logic                   busy_o,
  output logic                   valid_o,
  output beat_t [LINE_BEATS-1:0] rdata_o,
  output id_t                    id_o
);

  logic active_q;
  // set while the write engine owns the transaction
  logic owner_wr_q;
  logic launch;

  // one transaction at a time, so both engines must be quiet
  assign launch     = req_i && !active_q && rd_idle_i && wr_idle_i;
  assign rd_start_o = launch && !we_i;
  assign wr_start_o = launch && we_i;

  assign gnt_o   = active_q && (owner_wr_q ? wr_gnt_i : rd_gnt_i);
  assign valid_o = active_q && (owner_wr_q ? wr_done_i : rd_done_i);
  assign rdata_o = owner_wr_q ? '0 : rd_data_i;
  assign id_o    = owner_wr_q ? wr_id_i : rd_id_i;
  assign busy_o  = active_q || launch;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q   <= 1'b0;
      owner_wr_q <= 1'b0;
    end else begin
      if (launch) begin
        active_q   <= 1'b1;
        owner_wr_q <= we_i;
      end else if (valid_o) begin
        active_q <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------
  a_one_engine: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_idle_i || wr_idle_i)
    else $error("read and write engines busy at the same time");

endmodule

// ==== source/axi_adapter_top.sv ====
// axi adapter top
// joins the request controller with the read and write engines
`timescale 1ns/100ps

module axi_adapter_top
  import adapter_pkg::*;
#(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // cache side
  input  logic                   req_i,
  input  logic                   we_i,
  input  req_kind_t              kind_i,
  input  logic [ADDR_WIDTH-1:0]  addr_i,
  input  logic [1:0]             size_i,
  input  id_t                    id_i,
  input  beat_t [LINE_BEATS-1:0] wdata_i,
  input  strb_t [LINE_BEATS-1:0] be_i,
  output logic                   gnt_o,
  output logic                   busy_o,
  output logic                   valid_o,
  output beat_t [LINE_BEATS-1:0] rdata_o,
  output id_t                    id_o,
  output logic                   crit_valid_o,
  output beat_t                  crit_word_o,
  // AXI side
  input  logic                   ar_ready_i,
  input  logic                   aw_ready_i,
  input  logic                   w_ready_i,
  input  logic                   r_valid_i,
  input  r_chan_t                r_i,
  input  logic                   b_valid_i,
  input  b_chan_t                b_i,
  output logic                   ar_valid_o,
  output addr_chan_t             ar_o,
  output logic                   aw_valid_o,
  output addr_chan_t             aw_o,
  output logic                   w_valid_o,
  output w_chan_t                w_o,
  output logic                   r_ready_o,
  output logic                   b_ready_o
);

  logic                   rd_start, rd_gnt, rd_done, rd_idle;
  logic                   wr_start, wr_gnt, wr_done, wr_idle;
  beat_t [LINE_BEATS-1:0] rd_line;
  id_t                    rd_id, wr_id;

  adapter_ctrl #(.LINE_BEATS(LINE_BEATS)) adapter_ctrl_inst (
    .clk_i, .rst_n_i, .req_i, .we_i,
    .rd_gnt_i(rd_gnt), .rd_done_i(rd_done), .rd_data_i(rd_line), .rd_id_i(rd_id),
    .rd_idle_i(rd_idle), .wr_gnt_i(wr_gnt), .wr_done_i(wr_done), .wr_id_i(wr_id),
    .wr_idle_i(wr_idle), .rd_start_o(rd_start), .wr_start_o(wr_start),
    .gnt_o, .busy_o, .valid_o, .rdata_o, .id_o
  );

  axi_read_engine #(.LINE_BEATS(LINE_BEATS)) axi_read_engine_inst (
    .clk_i, .rst_n_i, .start_i(rd_start), .kind_i, .addr_i, .size_i, .id_i,
    .ar_ready_i, .r_valid_i, .r_i, .ar_valid_o, .ar_o, .r_ready_o,
    .gnt_o(rd_gnt), .done_o(rd_done), .line_o(rd_line), .id_o(rd_id),
    .crit_valid_o, .crit_word_o, .idle_o(rd_idle)
  );

  axi_write_engine #(.LINE_BEATS(LINE_BEATS)) axi_write_engine_inst (
    .clk_i, .rst_n_i, .start_i(wr_start), .kind_i, .addr_i, .size_i, .id_i,
    .wdata_i, .be_i, .aw_ready_i, .w_ready_i, .b_valid_i, .b_i,
    .aw_valid_o, .aw_o, .w_valid_o, .w_o, .b_ready_o,
    .gnt_o(wr_gnt), .done_o(wr_done), .id_o(wr_id), .idle_o(wr_idle)
  );

endmodule

// ==== testbench/tb_axi_slave.sv ====
// axi slave model
// 64-beat memory with pseudo-random ready and valid delays, OKAY responses
`timescale 1ns/100ps

module tb_axi_slave
  import adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       ar_valid_i,
  input  addr_chan_t ar_i,
  output logic       ar_ready_o,
  output logic       r_valid_o,
  output r_chan_t    r_o,
  input  logic       r_ready_i,
  input  logic       aw_valid_i,
  input  addr_chan_t aw_i,
  output logic       aw_ready_o,
  input  logic       w_valid_i,
  input  w_chan_t    w_i,
  output logic       w_ready_o,
  output logic       b_valid_o,
  output b_chan_t    b_o,
  input  logic       b_ready_i
);

  beat_t       mem [64];
  logic [31:0] lcg_q;
  logic [1:0]  ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic        rd_busy;
  logic [5:0]  rd_idx;
  logic [7:0]  rd_left;
  id_t         rd_id;
  logic        aw_got, w_got, b_pend;
  logic [5:0]  wr_idx;
  id_t         wr_id;
  int          w_cnt;
  beat_t       w_data_q [8];
  strb_t       w_strb_q [8];

  // next LCG state with bits 17:16 as a delay of 0 to 3 cycles
  function automatic logic [1:0] next_delay();
    lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
    return lcg_q[17:16];
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      lcg_q = 32'd58;
      // fill depends on the whole beat index
      for (int i = 0; i < 64; i++) begin
        mem[i] <= {16'hC0DE ^ 16'(i), 16'(i * 3), 32'h5A5A_0F0F ^ 32'(i * 32'h0101_0101)};
      end
      {ar_ready_o, r_valid_o, aw_ready_o, w_ready_o, b_valid_o} <= '0;
      {rd_busy, aw_got, w_got, b_pend} <= '0;
      {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
      w_cnt <= 0;
      r_o   <= '0;
      b_o   <= '0;
    end else begin
      // ------------------------------------------------------------------
      // read side
      // ------------------------------------------------------------------
      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        ar_wait    <= next_delay();
        rd_busy    <= 1'b1;
        rd_idx     <= ar_i.addr[BEAT_OFFSET +: 6];
        rd_left    <= ar_i.len;
        rd_id      <= ar_i.id;
      end else if (ar_valid_i && !rd_busy) begin
        if (ar_wait == 2'd0) ar_ready_o <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        r_wait    <= next_delay();
        if (r_o.last) rd_busy <= 1'b0;
        rd_idx    <= rd_idx + 6'd1;
        rd_left   <= rd_left - 8'd1;
      end else if (rd_busy && !r_valid_o) begin
        if (r_wait == 2'd0) begin
          r_valid_o <= 1'b1;
          r_o.data  <= mem[rd_idx];
          r_o.id    <= rd_id;
          r_o.last  <= (rd_left == 8'd0);
          r_o.resp  <= 2'b00;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
      // ------------------------------------------------------------------
      // write side with buffered beats so W may run ahead of AW
      // ------------------------------------------------------------------
      if (aw_valid_i && aw_ready_o) begin
        aw_ready_o <= 1'b0;
        aw_wait    <= next_delay();
        aw_got     <= 1'b1;
        wr_idx     <= aw_i.addr[BEAT_OFFSET +: 6];
        wr_id      <= aw_i.id;
      end else if (aw_valid_i && !aw_got) begin
        if (aw_wait == 2'd0) aw_ready_o <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end
      if (w_valid_i && w_ready_o) begin
        w_ready_o       <= 1'b0;
        w_wait          <= next_delay();
        w_data_q[w_cnt] <= w_i.data;
        w_strb_q[w_cnt] <= w_i.strb;
        w_cnt           <= w_cnt + 1;
        if (w_i.last) w_got <= 1'b1;
      end else if (w_valid_i && !w_got) begin
        if (w_wait == 2'd0) w_ready_o <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end
      if (aw_got && w_got && !b_pend) begin
        for (int k = 0; k < w_cnt; k++) begin
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (w_strb_q[k][b]) mem[wr_idx + 6'(k)][8*b +: 8] <= w_data_q[k][8*b +: 8];
          end
        end
        b_pend <= 1'b1;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        b_wait    <= next_delay();
        {b_pend, aw_got, w_got} <= '0;
        w_cnt     <= 0;
      end else if (b_pend && !b_valid_o) begin
        if (b_wait == 2'd0) begin
          b_valid_o <= 1'b1;
          b_o.id    <= wr_id;
          b_o.resp  <= 2'b00;
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
    end
  end

endmodule

// ==== testbench/tb_axi_adapter.sv ====
// adapter testbench
// table-driven single and line requests against the AXI slave model
`timescale 1ns/100ps

module tb_axi_adapter
  import adapter_pkg::*;
();

  localparam int LINE_BEATS = 4;
  localparam int NUM_FIXED  = 4;
  localparam int NUM_TESTS  = NUM_FIXED + 20;
  localparam int TIMEOUT    = 200;

  typedef struct packed {
    logic                   we;
    req_kind_t              kind;
    logic [ADDR_WIDTH-1:0]  addr;
    id_t                    id;
    beat_t [LINE_BEATS-1:0] data;
    strb_t [LINE_BEATS-1:0] be;
  } test_vec_t;

  logic                   clk, rst_n, req, we;
  req_kind_t              kind;
  logic [ADDR_WIDTH-1:0]  addr;
  logic [1:0]             size;
  id_t                    id, rid;
  beat_t [LINE_BEATS-1:0] wdata, rdata;
  strb_t [LINE_BEATS-1:0] be;
  logic                   gnt, busy, valid, crit_valid;
  beat_t                  crit_word;
  logic                   ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic                   r_valid, r_ready, b_valid, b_ready;
  addr_chan_t             ar, aw;
  w_chan_t                w;
  r_chan_t                r;
  b_chan_t                b;

  beat_t       ref_mem [64];
  test_vec_t   table_q [NUM_TESTS];
  int          err_count, pass_count, fail_count;
  bit          timed_out;
  logic [31:0] rand_q;

  axi_adapter_top #(.LINE_BEATS(LINE_BEATS)) axi_adapter_top_inst (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(req), .we_i(we), .kind_i(kind), .addr_i(addr),
    .size_i(size), .id_i(id), .wdata_i(wdata), .be_i(be), .gnt_o(gnt), .busy_o(busy),
    .valid_o(valid), .rdata_o(rdata), .id_o(rid), .crit_valid_o(crit_valid),
    .crit_word_o(crit_word), .ar_ready_i(ar_ready), .aw_ready_i(aw_ready),
    .w_ready_i(w_ready), .r_valid_i(r_valid), .r_i(r), .b_valid_i(b_valid), .b_i(b),
    .ar_valid_o(ar_valid), .ar_o(ar), .aw_valid_o(aw_valid), .aw_o(aw),
    .w_valid_o(w_valid), .w_o(w), .r_ready_o(r_ready), .b_ready_o(b_ready)
  );

  tb_axi_slave tb_axi_slave_inst (
    .clk_i(clk), .rst_n_i(rst_n), .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready), .aw_valid_i(aw_valid), .aw_i(aw),
    .aw_ready_o(aw_ready), .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rand_q = rand_q * 32'd1664525 + 32'd1013904223;
    return rand_q;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
    err_count++;
  endtask

  // merge a write into the reference memory by byte enables
  task automatic apply_write(input test_vec_t t);
    int first;
    int beats;
    first = int'(t.addr[BEAT_OFFSET +: 6]);
    beats = 1;
    if (t.kind == LINE_REQ) begin
      first = (first / LINE_BEATS) * LINE_BEATS;
      beats = LINE_BEATS;
    end
    for (int k = 0; k < beats; k++) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (t.be[k][b]) ref_mem[(first + k) % 64][8*b +: 8] = t.data[k][8*b +: 8];
      end
    end
  endtask

  // compare an AR or AW payload with the request it came from
  task automatic check_addr_chan(input string name, input addr_chan_t act,
                                 input test_vec_t t);
    logic [ADDR_WIDTH-1:0] exp_addr;
    logic [7:0]            exp_len;
    exp_addr = t.addr;
    exp_len = 8'd0;
    if (t.kind == LINE_REQ) begin
      // line bursts start at the line base
      exp_addr = t.addr & ~ADDR_WIDTH'(LINE_BEATS * STRB_WIDTH - 1);
      exp_len = 8'(LINE_BEATS - 1);
    end
    if (act.addr !== exp_addr) begin
      report_mismatch({name, ".addr"}, 64'(exp_addr), 64'(act.addr));
    end
    if (act.len !== exp_len) report_mismatch({name, ".len"}, 64'(exp_len), 64'(act.len));
    // size_i is driven as 3 so every beat is a full 8 bytes
    if (act.size !== 3'd3) report_mismatch({name, ".size"}, 64'd3, 64'(act.size));
  endtask

  task automatic build_table();
    test_vec_t   t;
    logic [31:0] rv;
    // partial single write, then read back the merged beat
    t = '0;
    t.we = 1'b1;
    t.addr = 32'h48;
    t.id = 4'h3;
    t.data[0] = 64'h1122_3344_5566_7788;
    t.be[0] = 8'h0F;
    table_q[0] = t;
    t = '0;
    t.addr = 32'h48;
    t.id = 4'h5;
    table_q[1] = t;
    // full line, then a line read whose critical word is beat 2
    t = '0;
    t.we = 1'b1;
    t.kind = LINE_REQ;
    t.addr = 32'h80;
    t.id = 4'h7;
    for (int k = 0; k < LINE_BEATS; k++) begin
      t.data[k] = {32'hA0A0_5A5A, 32'(k)};
      t.be[k] = 8'hFF;
    end
    table_q[2] = t;
    t = '0;
    t.kind = LINE_REQ;
    t.addr = 32'h94;
    t.id = 4'h9;
    table_q[3] = t;
    for (int n = NUM_FIXED; n < NUM_TESTS; n++) begin
      rv = next_rand();
      t = '0;
      t.we = rv[20];
      t.kind = req_kind_t'(rv[21]);
      t.addr = 32'(rv[8:0]);
      t.id = rv[27:24];
      for (int k = 0; k < LINE_BEATS; k++) begin
        t.data[k] = {next_rand(), next_rand()};
        rv = next_rand();
        t.be[k] = rv[23:16];
      end
      table_q[n] = t;
    end
  endtask

  task automatic run_test(input int n);
    test_vec_t t;
    beat_t     exp_line [LINE_BEATS];
    beat_t     crit_seen;
    int        first, crit_idx, errs_at_start;
    int        cyc, last_cyc, gnt_cnt, crit_cnt;
    bit        done;
    t = table_q[n];
    errs_at_start = err_count;
    first = int'(t.addr[BEAT_OFFSET +: 6]);
    crit_idx = 0;
    if (t.kind == LINE_REQ) begin
      crit_idx = first % LINE_BEATS;
      first = first - crit_idx;
    end
    if (t.we) apply_write(t);
    for (int k = 0; k < LINE_BEATS; k++) begin
      exp_line[k] = ref_mem[(first + k) % 64];
    end
    we = t.we;
    kind = t.kind;
    addr = t.addr;
    size = 2'd3;
    id = t.id;
    wdata = t.data;
    be = t.be;
    req = 1'b1;
    cyc = 0;
    last_cyc = -10;
    gnt_cnt = 0;
    crit_cnt = 0;
    crit_seen = '0;
    done = 1'b0;
    while (!done && cyc < TIMEOUT) begin
      @(negedge clk);
      if (gnt) gnt_cnt++;
      if (crit_valid) begin
        crit_cnt++;
        crit_seen = crit_word;
      end
      if (ar_valid && ar_ready) check_addr_chan("ar_o", ar, t);
      if (aw_valid && aw_ready) check_addr_chan("aw_o", aw, t);
      if (r_valid && r_ready && r.last) last_cyc = cyc;
      if (valid) begin
        done = 1'b1;
      end else begin
        @(posedge clk);
        #2;
        // request is held until the grant has been seen
        if (gnt_cnt > 0) req = 1'b0;
        cyc++;
      end
    end
    if (!done) begin
      $display("test %0d: timeout, no valid_o within %0d cycles", n, TIMEOUT);
      timed_out = 1'b1;
      fail_count++;
    end else begin
      if (gnt_cnt != 1) report_mismatch("gnt_o pulses", 64'd1, 64'(gnt_cnt));
      if (busy !== 1'b1) report_mismatch("busy_o", 64'd1, 64'(busy));
      if (rid !== t.id) report_mismatch("id_o", 64'(t.id), 64'(rid));
      if (!t.we) begin
        for (int k = 0; k < LINE_BEATS; k++) begin
          if ((t.kind == LINE_REQ || k == 0) && rdata[k] !== exp_line[k]) begin
            report_mismatch($sformatf("rdata_o[%0d]", k), exp_line[k], rdata[k]);
          end
        end
        if (crit_cnt != 1) report_mismatch("crit_valid_o pulses", 64'd1, 64'(crit_cnt));
        if (crit_seen !== exp_line[crit_idx]) begin
          report_mismatch("crit_word_o", exp_line[crit_idx], crit_seen);
        end
        if (cyc != last_cyc + 1) begin
          report_mismatch("valid_o cycles after r last", 64'd1, 64'(cyc - last_cyc));
        end
      end else begin
        // write completions carry no read data
        for (int k = 0; k < LINE_BEATS; k++) begin
          if (rdata[k] !== '0) report_mismatch($sformatf("rdata_o[%0d]", k), 64'd0, rdata[k]);
        end
        if (crit_cnt != 0) report_mismatch("crit_valid_o pulses", 64'd0, 64'(crit_cnt));
      end
      @(posedge clk);
      #2;
      req = 1'b0;
      @(negedge clk);
      if (busy !== 1'b0) report_mismatch("busy_o after valid_o", 64'd0, 64'(busy));
      if (valid !== 1'b0) report_mismatch("valid_o after valid_o", 64'd0, 64'(valid));
      @(posedge clk);
      #2;
      if (err_count == errs_at_start) begin
        pass_count++;
        $display("test %0d: ok (%s %s)", n, t.we ? "write" : "read", t.kind.name());
      end else begin
        fail_count++;
        $display("test %0d: failed (%s %s)", n, t.we ? "write" : "read", t.kind.name());
      end
    end
  endtask

  // outputs stay quiet between reset and the first request
  task automatic check_idle_after_reset();
    int errs_at_start;
    errs_at_start = err_count;
    repeat (3) begin
      @(negedge clk);
      if (busy !== 1'b0) report_mismatch("busy_o", 64'd0, 64'(busy));
      if (valid !== 1'b0) report_mismatch("valid_o", 64'd0, 64'(valid));
      if (gnt !== 1'b0) report_mismatch("gnt_o", 64'd0, 64'(gnt));
      if (crit_valid !== 1'b0) report_mismatch("crit_valid_o", 64'd0, 64'(crit_valid));
      if (ar_valid !== 1'b0) report_mismatch("ar_valid_o", 64'd0, 64'(ar_valid));
      if (aw_valid !== 1'b0) report_mismatch("aw_valid_o", 64'd0, 64'(aw_valid));
      if (w_valid !== 1'b0) report_mismatch("w_valid_o", 64'd0, 64'(w_valid));
      if (r_ready !== 1'b0) report_mismatch("r_ready_o", 64'd0, 64'(r_ready));
      if (b_ready !== 1'b0) report_mismatch("b_ready_o", 64'd0, 64'(b_ready));
    end
    @(posedge clk);
    #2;
    if (err_count == errs_at_start) begin
      pass_count++;
      $display("reset check: ok");
    end else begin
      fail_count++;
      $display("reset check: failed");
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    kind = SINGLE_REQ;
    addr = '0;
    size = '0;
    id = '0;
    wdata = '0;
    be = '0;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    timed_out = 1'b0;
    rand_q = 32'd58;
    build_table();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // slave memory was filled during reset
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = tb_axi_slave_inst.mem[i];
    end
    check_idle_after_reset();
    for (int i = 0; i < NUM_TESTS && !timed_out; i++) begin
      run_test(i);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_count + fail_count, pass_count, fail_count, err_count);
    if (err_count == 0 && fail_count == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
source/adapter_pkg.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/adapter_ctrl.sv
source/axi_adapter_top.sv
testbench/tb_axi_slave.sv
testbench/tb_axi_adapter.sv

// ==== Makefile ====
# Verilator build and run for the AXI cache adapter

VERILATOR ?= verilator
TOP       ?= tb_axi_adapter
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
